// File: memSubsys.f
verilog/memPkg.sv
verilog/memRequestLatch.sv
verilog/byteLaneArray.sv
verilog/loadFormatter.sv
verilog/memSubsysTop.sv
tb/memSubsys_assertions.sv
tb/memSubsysTb.sv

// File: tb/memSubsys_testdata.txt
# test readWrite(1 read, 0 write) ms address dataIn expectedDataOut, all hex but test
# ms bit 2 is signed, ms 3 and 7 reserved; a write expects dataOut unchanged
# word store, word and byte and halfword loads, big-endian lanes
 1 0 2 00000000 11223344 00000000
 2 1 2 00000000 00000000 11223344
 3 1 0 00000000 00000000 00000011
 4 1 0 00000001 00000000 00000022
 5 1 0 00000002 00000000 00000033
 6 1 0 00000003 00000000 00000044
 7 1 1 00000000 00000000 00001122
 8 1 1 00000002 00000000 00003344
 9 0 2 00000004 CAFEF00D 00003344
10 1 2 00000004 00000000 CAFEF00D
# partial stores touch only their lanes
11 0 2 00000010 01020304 CAFEF00D
12 0 0 00000011 FFFFFFAB CAFEF00D
13 1 2 00000010 00000000 01AB0304
14 0 0 00000013 0000005C 01AB0304
15 1 2 00000010 00000000 01AB035C
16 0 1 00000012 1234BEEF 01AB035C
17 1 2 00000010 00000000 01ABBEEF
18 0 1 00000010 00007788 01ABBEEF
19 1 2 00000010 00000000 7788BEEF
20 0 0 00000010 00000099 7788BEEF
21 1 2 00000010 00000000 9988BEEF
# sign and zero extension
22 0 2 00000020 807FFF01 9988BEEF
23 1 4 00000020 00000000 FFFFFF80
24 1 0 00000020 00000000 00000080
25 1 4 00000021 00000000 0000007F
26 1 4 00000022 00000000 FFFFFFFF
27 1 4 00000023 00000000 00000001
28 1 5 00000020 00000000 FFFF807F
29 1 1 00000020 00000000 0000807F
30 1 5 00000022 00000000 FFFFFF01
31 1 1 00000022 00000000 0000FF01
32 1 5 00000004 00000000 FFFFCAFE
33 1 5 00000006 00000000 FFFFF00D
34 1 4 00000007 00000000 0000000D
35 1 5 00000000 00000000 00001122
36 1 6 00000020 00000000 807FFF01
# forced alignment and address wrap
37 1 1 00000003 00000000 00003344
38 1 5 00000021 00000000 FFFF807F
39 0 1 00000031 0000A1B2 FFFF807F
40 0 1 00000033 0000C3D4 FFFF807F
41 1 2 00000030 00000000 A1B2C3D4
42 1 2 00000013 00000000 9988BEEF
43 0 2 00000046 55667788 9988BEEF
44 1 2 00000044 00000000 55667788
45 1 2 00000100 00000000 11223344
46 1 0 FFFFFF05 00000000 000000FE
47 0 2 012345FC 0BADF00D 000000FE
48 1 2 000000FC 00000000 0BADF00D
49 1 4 000001FD 00000000 FFFFFFAD
50 1 1 000002FF 00000000 0000F00D
# stores attempted while busy left no trace
51 1 2 00000000 00000000 11223344
52 1 2 00000004 00000000 CAFEF00D
# reserved size
53 1 3 00000010 00000000 00000000
54 0 3 00000010 FFFFFFFF 00000000
55 1 2 00000010 00000000 9988BEEF
56 1 7 00000020 00000000 00000000
57 1 2 00000030 00000000 A1B2C3D4
58 0 0 00000030 0000001E A1B2C3D4
59 0 3 00000030 FFFFFFFF A1B2C3D4
60 1 2 00000030 00000000 1EB2C3D4

// File: tb/memSubsysTb.sv
`timescale 1ns/100ps

module memSubsysTb;

	localparam int clkPeriod   = 20;			// ns.
	localparam int resetCycles = 8;
	localparam int cyclesPerOp = 12;			// Watchdog budget per data line.
	localparam int mocLatency  = 2;			// Acceptance edge to moc high.
	localparam int maxRelease  = 5;			// Longest mocOff delay in cycles.
	localparam logic [31:0] busyWriteData = 32'h5AC3_3CA5;	// Store that must never land.
	localparam string dataPath = "tb/memSubsys_testdata.txt";

	logic        clk;
	logic        arstN;
	logic        mov;
	logic        readWrite;
	logic [2:0]  ms;
	logic [31:0] address;
	logic [31:0] dataIn;
	logic        mocOff;
	logic        moc;
	logic [31:0] dataOut;

	// One entry per data line.
	int          opNum[$];
	logic        opRw[$];
	logic [2:0]  opMs[$];
	logic [31:0] opAddr[$];
	logic [31:0] opDin[$];
	logic [31:0] opExp[$];

	int errorCount;					// All failed checks.
	int testsClean;
	int testsBad;
	bit loaded;					// Data file read, watchdog may start.

	memSubsysTop u_dut (
		.clk       (clk),
		.arstN     (arstN),
		.mov       (mov),
		.readWrite (readWrite),
		.ms        (ms),
		.address   (address),
		.dataIn    (dataIn),
		.mocOff    (mocOff),
		.moc       (moc),
		.dataOut   (dataOut)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	task automatic reportMismatch(input string sigName, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("ERROR at %0t ns: %s expected %h actual %h", $time, sigName, expected, actual);
		errorCount++;
	endtask

	task automatic reportProblem(input string text);
		$display("Problem at %0t ns: %s", $time, text);
		errorCount++;
	endtask

	task automatic loadTestData();
		int          fd;
		int          fields;
		int          num;
		string       line;
		logic        rw;
		logic [2:0]  size;
		logic [31:0] addr;
		logic [31:0] din;
		logic [31:0] expected;
		fd = $fopen(dataPath, "r");
		if (fd == 0)
		begin
			reportProblem("could not open the test data file");
			return;
		end
		while (!$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line[0] == "#")
				continue;				// Blank or comment line.
			fields = $sscanf(line, "%d %h %h %h %h %h", num, rw, size, addr, din, expected);
			if (fields != 6)
			begin
				reportProblem({"malformed test data line: ", line});
				continue;
			end
			opNum.push_back(num);
			opRw.push_back(rw);
			opMs.push_back(size);
			opAddr.push_back(addr);
			opDin.push_back(din);
			opExp.push_back(expected);
		end
		$fclose(fd);
	endtask

	// One request from acceptance to closed, with a store attempted while busy.
	task automatic runOperation(input int idx);
		int    waited;
		int    holdCycles;
		int    errorsBefore;
		string kind;
		errorsBefore = errorCount;
		kind = opRw[idx] ? "read " : "write";
		if (moc !== 1'b0)
			reportProblem($sformatf("moc already high before test %0d", opNum[idx]));
		mov = 1'b1;
		readWrite = opRw[idx];
		ms = opMs[idx];
		address = opAddr[idx];
		dataIn = opDin[idx];
		@(posedge clk);					// Accepting edge.
		@(negedge clk);
		readWrite = 1'b0;				// mov stays high, word store to same address.
		ms = 3'b010;
		dataIn = busyWriteData;
		waited = 0;
		while (moc !== 1'b1 && waited < mocLatency)
		begin
			@(negedge clk);
			waited++;
		end
		if (moc !== 1'b1)
			reportProblem($sformatf("moc did not rise within %0d cycles in test %0d",
				mocLatency, opNum[idx]));
		else if (waited != mocLatency)
			reportMismatch("moc latency", mocLatency, waited);
		if (dataOut !== opExp[idx])
			reportMismatch("dataOut", opExp[idx], dataOut);
		holdCycles = $urandom % (maxRelease + 1);	// Processor slow to acknowledge.
		repeat (holdCycles)
		begin
			@(negedge clk);
			if (moc !== 1'b1)
				reportProblem($sformatf("moc dropped before mocOff in test %0d", opNum[idx]));
			if (dataOut !== opExp[idx])
				reportMismatch("dataOut", opExp[idx], dataOut);
		end
		mocOff = 1'b1;
		mov = 1'b0;
		@(negedge clk);
		mocOff = 1'b0;
		if (moc !== 1'b0)
			reportProblem($sformatf("moc still high after mocOff in test %0d", opNum[idx]));
		if (errorCount == errorsBefore)
			testsClean++;
		else
			testsBad++;
		$display("Test %0d %s ms %0d address %h hold %0d: %s", opNum[idx], kind, opMs[idx],
			opAddr[idx], holdCycles, (errorCount == errorsBefore) ? "ok" : "errors");
	endtask

	initial
	begin : watchdog
		wait (loaded);
		#((opNum.size() * cyclesPerOp + resetCycles) * clkPeriod);
		$display("Watchdog expired, the DUT appears hung and the run did not complete");
		$display("Regression failed");
		$finish;
	end

	initial
	begin : mainFlow
		int seedValue;
		seedValue = $urandom(32'h05839667);		// Seeds the generator once.
		errorCount = 0;
		testsClean = 0;
		testsBad = 0;
		loaded = 1'b0;
		arstN = 1'b0;
		mov = 1'b0;
		readWrite = 1'b1;
		ms = 3'b000;
		address = '0;
		dataIn = '0;
		mocOff = 1'b0;
		loadTestData();
		if (opNum.size() == 0)
			reportProblem("the test data file holds no operations");
		loaded = 1'b1;
		repeat (resetCycles) @(negedge clk);
		arstN = 1'b1;
		@(negedge clk);
		if (moc !== 1'b0)
			reportMismatch("moc", 32'd0, moc);
		if (dataOut !== '0)
			reportMismatch("dataOut", 32'd0, dataOut);
		mocOff = 1'b1;					// Stray acknowledge, nothing open.
		@(negedge clk);
		mocOff = 1'b0;
		@(negedge clk);
		if (moc !== 1'b0)
			reportProblem("moc rose after mocOff with no request open");
		for (int i = 0; i < opNum.size(); i++)
			runOperation(i);
		$display("Totals: %0d tests, %0d clean, %0d with errors, %0d errors overall",
			opNum.size(), testsClean, testsBad, errorCount);
		if (errorCount == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// File: tb/memSubsys_assertions.sv
`timescale 1ns/100ps

module memSubsys_assertions (
	input logic        clk,
	input logic        arstN,
	input logic        reqValid,
	input logic        moc,
	input logic        mocOff,
	input logic [31:0] dataOut
);

	localparam int mocLatency = 2;			// Acceptance edge to moc high.

	// reqQ.valid is high for the one cycle after the accepting edge.
	property mocAfterAccept;
		@(posedge clk) disable iff (!arstN)
		reqValid |-> ##mocLatency $rose(moc);
	endproperty

	property mocFallsOnAck;
		@(posedge clk) disable iff (!arstN)
		(moc && mocOff) |=> !moc;		// Cleared on the sampling edge.
	endproperty

	property dataOutHeld;
		@(posedge clk) disable iff (!arstN)
		moc |=> (!moc || $stable(dataOut));
	endproperty

	property mocNeedsAccept;
		@(posedge clk) disable iff (!arstN)
		$rose(moc) |-> $past(reqValid, mocLatency);
	endproperty

	assert property (mocAfterAccept)
	else
		$error("moc did not rise %0d cycles after an accepted request", mocLatency);
	assert property (mocFallsOnAck)
	else
		$error("moc stayed high after mocOff was sampled");
	assert property (dataOutHeld)
	else
		$error("dataOut changed while moc was high");
	assert property (mocNeedsAccept)
	else
		$error("moc rose without an accepted request");

endmodule

bind memSubsysTop memSubsys_assertions u_assertions (
	.clk      (clk),
	.arstN    (arstN),
	.reqValid (reqQ.valid),
	.moc      (moc),
	.mocOff   (mocOff),
	.dataOut  (dataOut)
);

// File: verilog/memSubsysTop.sv
`timescale 1ns/100ps

module memSubsysTop (
	input  logic        clk,
	input  logic        arstN,
	input  logic        mov,
	input  logic        readWrite,
	input  logic [2:0]  ms,
	input  logic [31:0] address,
	input  logic [31:0] dataIn,
	input  logic        mocOff,
	output logic        moc,
	output logic [31:0] dataOut
);

	memPkg::memReq_t reqQ;				// Accepted request.
	memPkg::memReq_t reqD;				// Request beside the read word.
	memPkg::lanes_t  rdLanes;			// Registered aligned word.

	memRequestLatch u_latch (
		.clk       (clk),
		.arstN     (arstN),
		.mov       (mov),
		.readWrite (readWrite),
		.ms        (ms),
		.address   (address),
		.dataIn    (dataIn),
		.mocOff    (mocOff),
		.reqQ      (reqQ)
	);

	byteLaneArray u_array (
		.clk     (clk),
		.arstN   (arstN),
		.reqQ    (reqQ),
		.rdLanes (rdLanes),
		.reqD    (reqD)
	);

	loadFormatter u_format (
		.clk     (clk),
		.arstN   (arstN),
		.reqD    (reqD),
		.rdLanes (rdLanes),
		.mocOff  (mocOff),
		.moc     (moc),
		.dataOut (dataOut)
	);

endmodule

// File: verilog/loadFormatter.sv
`timescale 1ns/100ps

module loadFormatter (
	input  logic             clk,
	input  logic             arstN,
	input  memPkg::memReq_t  reqD,
	input  memPkg::lanes_t   rdLanes,
	input  logic             mocOff,
	output logic             moc,
	output logic [31:0]      dataOut
);

	logic [7:0]  loadByte;				// Selected byte lane.
	logic [15:0] loadHalf;				// Selected lane pair.
	logic [1:0]  hiLane;				// First lane of the halfword.
	logic        signFill;				// Value for the upper bits.
	logic [31:0] loadValue;				// Formatted load result.

	assign hiLane   = {reqD.byteAddr[1], 1'b0};	// Even address below.
	assign loadByte = rdLanes[reqD.byteAddr[1:0]];
	assign loadHalf = {rdLanes[hiLane], rdLanes[hiLane + 2'd1]};	// Big-endian pair.

	always_comb
	begin
		signFill = 1'b0;
		case (reqD.size)
			memPkg::sizeByte:
			begin
				signFill = reqD.isSigned && loadByte[7];	// Ones only if negative.
				loadValue = {{24{signFill}}, loadByte};
			end
			memPkg::sizeHalf:
			begin
				signFill = reqD.isSigned && loadHalf[15];
				loadValue = {{16{signFill}}, loadHalf};
			end
			memPkg::sizeWord:
				loadValue = rdLanes;		// All four lanes in order.
			memPkg::sizeReserved:
				loadValue = '0;			// Reserved size reads zero.
		endcase
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			moc <= 1'b0;
			dataOut <= '0;
		end
		else
		begin
			if (reqD.valid && !reqD.write)
				dataOut <= loadValue;		// Stores leave dataOut alone.
			if (reqD.valid)
				moc <= 1'b1;			// Operation complete.
			else if (mocOff && moc)
				moc <= 1'b0;			// Processor acknowledged.
		end
	end

endmodule

// File: verilog/byteLaneArray.sv
`timescale 1ns/100ps

module byteLaneArray (
	input  logic             clk,
	input  logic             arstN,
	input  memPkg::memReq_t  reqQ,
	output memPkg::lanes_t   rdLanes,
	output memPkg::memReq_t  reqD
);

	localparam int laneCount = memPkg::memBytes / memPkg::bankDepth;	// Four banks.

	memPkg::lanes_t bankRd;				// Current row of all banks.
	logic           doWrite;				// Store request this cycle.

	assign doWrite = reqQ.valid && reqQ.write;

	// One bank per big-endian lane, all addressed by the same row.
	for (genvar lane = 0; lane < laneCount; lane++)
	begin : genBank
		logic [7:0] bankMem [memPkg::bankDepth];	// Contents are not reset.

		always_ff @(posedge clk)
		begin
			if (doWrite && reqQ.laneEn[lane])
				bankMem[reqQ.wordIdx] <= reqQ.wrData[lane];	// Only enabled lanes.
		end

		assign bankRd[lane] = bankMem[reqQ.wordIdx];		// Old data on a store.
	end

	// Aligned word captured for every request, used only by loads.
	always_ff @(posedge clk)
	begin
		if (reqQ.valid)
			rdLanes <= bankRd;
	end

	// Request follows the data one stage down.
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			reqD <= '0;
		else if (reqQ.valid)
			reqD <= reqQ;
		else
			reqD.valid <= 1'b0;
	end

endmodule

// File: verilog/memRequestLatch.sv
`timescale 1ns/100ps

module memRequestLatch (
	input  logic             clk,
	input  logic             arstN,
	input  logic             mov,
	input  logic             readWrite,
	input  logic [2:0]       ms,
	input  logic [31:0]      address,
	input  logic [31:0]      dataIn,
	input  logic             mocOff,
	output memPkg::memReq_t  reqQ
);

	logic                        busy;		// A request is open.
	logic                        pipeBusy;	// Request one stage past the latch.
	logic                        accept;		// Take the inputs on this edge.
	logic [memPkg::addrBits-1:0] rawAddr;	// Address wrapped to the array.
	logic [memPkg::addrBits-1:0] alignedAddr;	// Base of the accessed unit.
	memPkg::memReq_t             nextReq;	// Request built from the inputs.

	assign accept  = mov && !busy;
	assign rawAddr = memPkg::addrBits'(address % memPkg::memBytes);	// High bits wrap.

	always_comb
	begin
		alignedAddr = rawAddr;
		nextReq = '0;
		nextReq.write = !readWrite;		// readWrite high means load.
		nextReq.size = ms[1:0];
		nextReq.isSigned = ms[2];
		nextReq.byteAddr = rawAddr;
		nextReq.valid = 1'b1;
		case (ms[1:0])
			memPkg::sizeByte:
			begin
				nextReq.laneEn[rawAddr[1:0]] = 1'b1;
				nextReq.wrData[rawAddr[1:0]] = dataIn[7:0];
			end
			memPkg::sizeHalf:
			begin
				alignedAddr[0] = 1'b0;		// Force even address.
				nextReq.laneEn[{rawAddr[1], 1'b0}] = 1'b1;
				nextReq.laneEn[{rawAddr[1], 1'b1}] = 1'b1;
				nextReq.wrData[{rawAddr[1], 1'b0}] = dataIn[15:8];	// High byte first.
				nextReq.wrData[{rawAddr[1], 1'b1}] = dataIn[7:0];
			end
			memPkg::sizeWord:
			begin
				alignedAddr[1:0] = 2'b00;	// Force word boundary.
				nextReq.laneEn = 4'b1111;
				nextReq.wrData = dataIn;
			end
			default:
				nextReq.laneEn = 4'b0000;	// Reserved size writes nothing.
		endcase
		nextReq.wordIdx = alignedAddr[memPkg::addrBits-1:2];
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			busy <= 1'b0;
			pipeBusy <= 1'b0;
			reqQ <= '0;
		end
		else
		begin
			pipeBusy <= reqQ.valid;
			if (accept)
				reqQ <= nextReq;		// Valid for one cycle.
			else
				reqQ.valid <= 1'b0;
			// Close only once moc can be up, so early mocOff is ignored.
			if (accept)
				busy <= 1'b1;
			else if (mocOff && !reqQ.valid && !pipeBusy)
				busy <= 1'b0;
		end
	end

endmodule

// File: verilog/memPkg.sv
package memPkg;

	localparam int memBytes  = 256;				// Total storage in bytes.
	localparam int addrBits  = 8;				// Address bits actually decoded.
	localparam int bankDepth = 64;				// Bytes held by each lane bank.

	// Two-bit size codes carried in ms[1:0].
	localparam logic [1:0] sizeByte     = 2'b00;	// Single byte.
	localparam logic [1:0] sizeHalf     = 2'b01;	// Halfword, even address.
	localparam logic [1:0] sizeWord     = 2'b10;	// Word, address multiple of four.
	localparam logic [1:0] sizeReserved = 2'b11;	// Completes but does nothing.

	// Lane 0 is the byte at the aligned base and sits in bits 31:24.
	typedef logic [0:3][7:0] lanes_t;

	// One accepted request as it moves down the pipeline.
	typedef struct packed {
		logic                  write;		// High for a store.
		logic [1:0]            size;		// Size code from ms[1:0].
		logic                  isSigned;	// Sign extension on loads.
		logic [addrBits-1:0]   byteAddr;	// Raw wrapped byte address.
		logic [addrBits-3:0]   wordIdx;		// Row inside each bank.
		logic [0:3]            laneEn;		// Lanes touched by this access.
		lanes_t                wrData;		// Store data on its lanes.
		logic                  valid;		// Request present this cycle.
	} memReq_t;

endpackage
